/* branchFetch.f */
+incdir+verilog
verilog/branchPkg.sv
verilog/fetchUnit.sv
verilog/instQueue.sv
verilog/branchUnit.sv
verilog/branchFetchTop.sv
testbench/clockGen.sv
testbench/branchFetch_checker.sv
testbench/branchFetchTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert \
  --top-module branchFetchTb \
  -f branchFetch.f \
  -o branchFetchSim
./obj_dir/branchFetchSim

/* testbench/branchFetchTb.sv */
`timescale 1ns/100ps
`include "branchFetch_config.svh"

module branchFetchTb import branchPkg::*; ();

  localparam logic [31:0] resetPc    = `BF_RESET_PC;
  localparam logic [31:0] lfsrSeed   = 32'd83465;
  localparam int          reqTimeout = 100;
  localparam int          retTimeout = 200;

  logic        gclk;
  logic        rstN;
  logic        fetchReq;
  logic [31:2] fetchAddr;
  logic        fetchAck;
  instWord     fetchInst;
  logic [31:0] fetchOperand;
  logic        retireValid;
  logic [31:2] retirePc;
  logic        retireTaken;

  // raw words from the stim file
  logic [31:0] stimMem [0:255];
  // program image, word addresses 0 to 255
  instWord     progInst [0:255];
  logic [31:0] progOperand [0:255];
  logic        progValid [0:255];
  // expected retire sequence
  logic [29:0] expPc [0:63];
  logic        expTaken [0:63];
  int          nProg;
  int          nRetire;
  int          matched;
  logic [31:0] lfsrState;

  clockGen uClock (.gclk, .rstN);

  branchFetchTop UUT (
    .gclk, .rstN,
    .fetchReq, .fetchAddr, .fetchAck, .fetchInst, .fetchOperand,
    .retireValid, .retirePc, .retireTaken
  );

  bind branchFetchTop branchFetchChecker uChecker (
    .gclk(gclk), .rstN(rstN), .fetchReq(fetchReq), .fetchAddr(fetchAddr),
    .fetchAck(fetchAck), .redirect(redirect), .retireValid(retireValid)
  );

  task automatic failNow(input string reason);
    $display("%s", reason);
    $display("tests failed");
    $fatal(1, "simulation stopped");
  endtask

  // right-shift galois form, taps 32 22 2 1
  function automatic logic [31:0] galoisStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // one lfsr step per bit taken
  task automatic takeBits(input int n, output int value);
    value = 0;
    for (int i = 0; i < n; i++) begin
      value = (value << 1) | int'(lfsrState[0]);
      lfsrState = galoisStep(lfsrState);
    end
  endtask

  // 0x24..0x27 slow, 0x28..0x2f back to back, else random 0..3
  task automatic pickDelay(input logic [29:0] wordAddr, output int cycles);
    if (wordAddr >= 30'h24 && wordAddr < 30'h28) begin
      cycles = 6;
    end else if (wordAddr >= 30'h28 && wordAddr < 30'h30) begin
      cycles = 0;
    end else begin
      takeBits(2, cycles);
    end
  endtask

  // filler for unmapped words, opcode 0o01 never decodes as a branch
  function automatic logic [31:0] fillInst(input logic [29:0] wordAddr);
    return {6'o01, wordAddr[25:0] ^ {22'd0, wordAddr[29:26]}};
  endfunction

  function automatic logic [31:0] fillOperand(input logic [29:0] wordAddr);
    return {wordAddr, 2'b00} ^ 32'h5a5a_0000;
  endfunction

  task automatic loadStim();
    int base;
    for (int i = 0; i < 256; i++) begin
      progValid[i] = 1'b0;
    end
    $readmemh("testbench/branchFetch_stim.txt", stimMem);
    nProg   = stimMem[0];
    nRetire = stimMem[1];
    if (nProg == 0 || nRetire == 0 || nRetire > 64) begin
      failNow("stimulus file missing or malformed");
    end
    // program triples follow the two counts
    base = 2;
    for (int i = 0; i < nProg; i++) begin
      progInst[stimMem[base][7:0]]    = stimMem[base + 1];
      progOperand[stimMem[base][7:0]] = stimMem[base + 2];
      progValid[stimMem[base][7:0]]   = 1'b1;
      base = base + 3;
    end
    for (int i = 0; i < nRetire; i++) begin
      expPc[i]    = stimMem[base][29:0];
      expTaken[i] = stimMem[base + 1][0];
      base = base + 2;
    end
    if (expPc[0] != resetPc[31:2]) begin
      failNow("first expected retire is not the reset PC");
    end
  endtask

  task automatic checkRetire(input int idx);
    assert (retirePc == expPc[idx]) else begin
      failNow($sformatf("Error retirePc expected %h actual %h", expPc[idx], retirePc));
    end
    assert (retireTaken == expTaken[idx]) else begin
      failNow($sformatf("Error retireTaken expected %h actual %h",
                        expTaken[idx], retireTaken));
    end
  endtask

  // four-phase slave, everything moves 1 ns after the edge
  initial begin : memoryModel
    int waitCount;
    int ackDelay;
    fetchAck     = 1'b0;
    fetchInst    = '0;
    fetchOperand = '0;
    lfsrState    = lfsrSeed;
    forever begin
      waitCount = 0;
      // request looked at 1 ns after each edge
      do begin
        @(posedge gclk);
        #1;
        waitCount++;
        if (waitCount > reqTimeout) begin
          failNow("no fetch request from the DUT within the timeout");
        end
      end while (!fetchReq);
      pickDelay(fetchAddr, ackDelay);
      repeat (ackDelay) begin
        @(posedge gclk);
        #1;
      end
      if (fetchAddr < 30'd256 && progValid[fetchAddr[9:2]]) begin
        fetchInst    = progInst[fetchAddr[9:2]];
        fetchOperand = progOperand[fetchAddr[9:2]];
      end else begin
        fetchInst    = fillInst(fetchAddr);
        fetchOperand = fillOperand(fetchAddr);
      end
      fetchAck  = 1'b1;
      waitCount = 0;
      // ack drops once the request is gone
      while (fetchReq) begin
        @(posedge gclk);
        #1;
        waitCount++;
        if (waitCount > reqTimeout) begin
          failNow("fetchReq still high long after fetchAck");
        end
      end
      fetchAck = 1'b0;
    end
  end

  initial begin : mainSeq
    int idle;
    loadStim();
    matched = 0;
    idle    = 0;
    while (matched < nRetire) begin
      @(posedge gclk);
      #1;
      if (retireValid) begin
        checkRetire(matched);
        matched++;
        idle = 0;
      end else begin
        idle++;
        if (idle > retTimeout) begin
          failNow("retire port stayed idle past the timeout");
        end
      end
    end
    $display("all tests passed");
    $finish;
  end

endmodule

/* testbench/branchFetch_checker.sv */
`timescale 1ns/100ps

module branchFetchChecker (
  input logic        gclk,
  input logic        rstN,
  input logic        fetchReq,
  input logic [31:2] fetchAddr,
  input logic        fetchAck,
  input logic        redirect,
  input logic        retireValid
);

  // request stays up until the memory acks
  reqHeld: assert property (@(posedge gclk) disable iff (!rstN)
    fetchReq && !fetchAck |=> fetchReq)
    else $error("fetchReq dropped before fetchAck");

  // address frozen for the whole request
  addrStable: assert property (@(posedge gclk) disable iff (!rstN)
    fetchReq |=> !fetchReq || $stable(fetchAddr))
    else $error("fetchAddr changed while fetchReq was high");

  // single-cycle redirect pulse
  redirectPulse: assert property (@(posedge gclk) disable iff (!rstN)
    redirect |=> !redirect)
    else $error("redirect held for more than one cycle");

  // nothing retires under reset
  quietReset: assert property (@(posedge gclk)
    !rstN |-> !retireValid)
    else $error("retireValid high during reset");

endmodule

/* testbench/branchFetch_stim.txt */
// counts: program lines, retire entries; program: word addr, instruction, operand
// retire list: word pc, taken bit, four pairs per line
1D 1F
00 10221800 00000000
01 20430005 00000011
02 98001000 FFFFFFFF
03 9C601800 00000000
04 B8000004 00000000
08 30A41234 00000022
09 B8100005 00000000
0A 40C50007 00000033
0E BE000004 00000000
0F B8000020 00000000
12 BC000002 00000000
14 BC000002 00000007
15 BC200002 FFFFFFF0
17 BC200002 00000000
18 BC400002 FFFFFFF0
1A BC400002 00000000
1B BC600002 00000000
1D BC600002 00000007
1E BC800002 00000007
20 BC800002 00000000
21 BCA00002 00000000
23 BCA00002 FFFFFFF0
24 50E60001 00000044
25 54E60002 00000055
26 60E60003 00000066
27 64E60004 00000077
28 70E60005 00000088
29 74E60006 00000099
2A B800FFFE 00000000
00 0 01 0 02 0 03 0
04 1 08 0 09 1 0A 0
0E 1 0F 0 12 1 14 0
15 1 17 0 18 1 1A 0
1B 1 1D 0 1E 1 20 0
21 1 23 0 24 0 25 0
26 0 27 0 28 0 29 0
2A 1 28 0 29 0

/* testbench/clockGen.sv */
`timescale 1ns/100ps

module clockGen (
  output logic gclk,
  output logic rstN
);

  // 40 ns period
  initial begin
    gclk = 1'b0;
    forever #20 gclk = ~gclk;
  end

  // reset held for 8 rising edges, released just after the last one
  initial begin
    rstN = 1'b0;
    repeat (8) @(posedge gclk);
    #1 rstN = 1'b1;
  end

endmodule

/* verilog/branchFetchTop.sv */
`timescale 1ns/100ps
`include "branchFetch_config.svh"

module branchFetchTop import branchPkg::*; (
  input  logic        gclk,
  input  logic        rstN,
  output logic        fetchReq,
  output logic [31:2] fetchAddr,
  input  logic        fetchAck,
  input  instWord     fetchInst,
  input  logic [31:0] fetchOperand,
  output logic        retireValid,
  output logic [31:2] retirePc,
  output logic        retireTaken
);

  // fetch to queue
  logic        pushValid;
  instWord     pushInst;
  logic [31:0] pushOperand;
  logic [31:2] pushPc;
  logic        full;

  // queue to branch unit
  logic        headValid;
  instWord     headInst;
  logic [31:0] headOperand;
  logic [31:2] headPc;
  logic        pop;

  // redirect also flushes the queue
  logic        redirect;
  logic [31:2] redirectPc;

  fetchUnit uFetch (
    .gclk, .rstN,
    .fetchReq, .fetchAddr, .fetchAck, .fetchInst, .fetchOperand,
    .pushValid, .pushInst, .pushOperand, .pushPc,
    .full, .redirect, .redirectPc
  );

  instQueue #(.depth(`BF_QUEUE_DEPTH)) uQueue (
    .gclk, .rstN,
    .pushValid, .pushInst, .pushOperand, .pushPc, .full,
    .headValid, .headInst, .headOperand, .headPc, .pop,
    .flush (redirect)
  );

  branchUnit uBranch (
    .gclk, .rstN,
    .headValid, .headInst, .headOperand, .headPc, .pop,
    .redirect, .redirectPc,
    .retireValid, .retireTaken, .retirePc
  );

endmodule

/* verilog/branchFetch_config.svh */
`ifndef BRANCHFETCH_CONFIG_SVH
`define BRANCHFETCH_CONFIG_SVH

// first fetch after reset, as a 32-bit byte address
// the fetch port carries bits [31:2] as the word address
`define BF_RESET_PC 32'h0000_0000

// entries in the instruction queue
// 2, 4 and 8 are all legal
`define BF_QUEUE_DEPTH 4

`endif

/* verilog/branchPkg.sv */
package branchPkg;

  // register-form view of an instruction word
  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] alt;
  } regFormT;

  // immediate-form view, low half is imm16
  typedef struct packed {
    logic [5:0]  opc;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;
  } immFormT;

  // one 32-bit word, two decodes
  typedef union packed {
    regFormT regForm;
    immFormT immForm;
  } instWord;

  // immediate branch opcodes
  localparam logic [5:0] opBru = 6'o56;
  localparam logic [5:0] opBcc = 6'o57;

  // conditions carried in rd[2:0] of a conditional branch
  typedef enum logic [2:0] {
    condEq = 3'd0,
    condNe = 3'd1,
    condLt = 3'd2,
    condLe = 3'd3,
    condGt = 3'd4,
    condGe = 3'd5
  } branchCond;

endpackage

/* verilog/branchUnit.sv */
`timescale 1ns/100ps

module branchUnit import branchPkg::*; (
  input  logic        gclk,
  input  logic        rstN,
  input  logic        headValid,
  input  instWord     headInst,
  input  logic [31:0] headOperand,
  input  logic [31:2] headPc,
  output logic        pop,
  output logic        redirect,
  output logic [31:2] redirectPc,
  output logic        retireValid,
  output logic        retireTaken,
  output logic [31:2] retirePc
);

  logic        isBru;
  logic        isBcc;
  branchCond   cond;
  logic        opZero;
  logic        opNeg;
  logic        leTrue;
  logic        condTrue;
  logic        delayBit;
  logic        taken;
  logic [31:2] target;

  // delay slot owed by an earlier taken branch
  logic        slotPending;
  logic [31:2] pendingTarget;

  // no pop in a redirect cycle, the queue is flushing
  assign pop = headValid && !redirect;

  // opcode decode
  assign isBru = (headInst.regForm.opc == opBru);
  assign isBcc = (headInst.regForm.opc == opBcc);
  assign cond  = branchCond'(headInst.regForm.rd[2:0]);

  // signed compare of operand against zero
  assign opZero = (headOperand == 32'd0);
  assign opNeg  = headOperand[31];
  assign leTrue = opNeg || opZero;

  always_comb begin
    case (cond)
      condEq:  condTrue = opZero;
      condNe:  condTrue = !opZero;
      condLt:  condTrue = opNeg;
      condLe:  condTrue = leTrue;
      // gt as an inverted le
      condGt:  condTrue = !leTrue;
      condGe:  condTrue = !opNeg;
      default: condTrue = 1'b0;
    endcase
  end

  // delay bit sits in ra for bru, rd for bcc
  assign delayBit = isBru ? headInst.regForm.ra[4] : headInst.immForm.rd[4];

  // a branch in a delay slot is an ordinary instruction
  assign taken = (isBru || (isBcc && condTrue)) && !slotPending;

  // pc-relative word target, imm16 sign-extended
  assign target = headPc + {{14{headInst.immForm.imm[15]}}, headInst.immForm.imm};

  // control state
  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      retireValid <= 1'b0;
      redirect    <= 1'b0;
      slotPending <= 1'b0;
    end else begin
      retireValid <= pop;
      redirect    <= 1'b0;
      if (pop) begin
        if (slotPending) begin
          // slot retires now, jump goes with it
          redirect    <= 1'b1;
          slotPending <= 1'b0;
        end else if (taken && !delayBit) begin
          redirect <= 1'b1;
        end else if (taken) begin
          slotPending <= 1'b1;
        end
      end
    end
  end

  // retire payload and targets
  always_ff @(posedge gclk) begin
    if (pop) begin
      retirePc    <= headPc;
      retireTaken <= taken;
      if (slotPending) begin
        redirectPc <= pendingTarget;
      end else if (taken && !delayBit) begin
        redirectPc <= target;
      end
      // held until the slot instruction pops
      if (taken && delayBit) begin
        pendingTarget <= target;
      end
    end
  end

endmodule

/* verilog/fetchUnit.sv */
`timescale 1ns/100ps
`include "branchFetch_config.svh"

module fetchUnit import branchPkg::*; (
  input  logic        gclk,
  input  logic        rstN,
  output logic        fetchReq,
  output logic [31:2] fetchAddr,
  input  logic        fetchAck,
  input  instWord     fetchInst,
  input  logic [31:0] fetchOperand,
  output logic        pushValid,
  output instWord     pushInst,
  output logic [31:0] pushOperand,
  output logic [31:2] pushPc,
  input  logic        full,
  input  logic        redirect,
  input  logic [31:2] redirectPc
);

  localparam logic [31:0] resetPc = `BF_RESET_PC;

  // four-phase master states
  typedef enum logic [1:0] {stIdle, stReq, stWait} fetchState;

  fetchState   state;
  // next word address to fetch
  logic [31:2] pc;
  // address held stable for the open request
  logic [31:2] reqAddr;
  // word in flight was overtaken by a redirect
  logic        discard;
  logic        capture;
  logic        startReq;

  // first cycle with ack seen high
  assign capture = (state == stReq) && fetchAck;
  // queue not full and no redirect pending
  assign startReq = (state == stIdle) && !full && !redirect;

  assign fetchReq  = (state == stReq);
  assign fetchAddr = reqAddr;

  // push straight from the memory bus in the capture cycle
  assign pushValid   = capture && !discard && !redirect;
  assign pushInst    = fetchInst;
  assign pushOperand = fetchOperand;
  assign pushPc      = reqAddr;

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      state   <= stIdle;
      pc      <= resetPc[31:2];
      reqAddr <= resetPc[31:2];
      discard <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          if (redirect) begin
            pc <= redirectPc;
          end else if (startReq) begin
            state   <= stReq;
            reqAddr <= pc;
          end
        end
        stReq: begin
          if (fetchAck) begin
            state   <= stWait;
            discard <= 1'b0;
            // kept word moves pc on, a dropped one leaves it alone
            if (redirect) begin
              pc <= redirectPc;
            end else if (!discard) begin
              pc <= pc + 30'd1;
            end
          end else if (redirect) begin
            // finish the handshake, drop the word later
            discard <= 1'b1;
            pc      <= redirectPc;
          end
        end
        stWait: begin
          if (redirect) begin
            pc <= redirectPc;
          end
          // ack low ends the four-phase cycle
          if (!fetchAck) begin
            state <= stIdle;
          end
        end
        default: state <= stIdle;
      endcase
    end
  end

endmodule

/* verilog/instQueue.sv */
`timescale 1ns/100ps

module instQueue import branchPkg::*; #(
  parameter int depth = 4
) (
  input  logic        gclk,
  input  logic        rstN,
  input  logic        pushValid,
  input  instWord     pushInst,
  input  logic [31:0] pushOperand,
  input  logic [31:2] pushPc,
  output logic        full,
  output logic        headValid,
  output instWord     headInst,
  output logic [31:0] headOperand,
  output logic [31:2] headPc,
  input  logic        pop,
  input  logic        flush
);

  localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;

  // payload storage
  instWord     instMem [depth];
  logic [31:0] operandMem [depth];
  logic [31:2] pcMem [depth];

  logic [ptrW-1:0] rdPtr;
  logic [ptrW-1:0] wrPtr;
  logic [ptrW:0]   count;
  logic            doPush;
  logic            doPop;

  assign full      = (count == (ptrW+1)'(depth));
  assign headValid = (count != '0);
  assign doPush    = pushValid && !full && !flush;
  assign doPop     = pop && headValid && !flush;

  // head entry read combinationally
  assign headInst    = instMem[rdPtr];
  assign headOperand = operandMem[rdPtr];
  assign headPc      = pcMem[rdPtr];

  // storage write
  always_ff @(posedge gclk) begin
    if (doPush) begin
      instMem[wrPtr]    <= pushInst;
      operandMem[wrPtr] <= pushOperand;
      pcMem[wrPtr]      <= pushPc;
    end
  end

  always_ff @(posedge gclk or negedge rstN) begin
    if (!rstN) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else if (flush) begin
      // flush wins over a same-cycle push
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + ptrW'(1);
      end
      if (doPop) begin
        rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + ptrW'(1);
      end
      // push and pop together leave count unchanged
      count <= count + {{ptrW{1'b0}}, doPush} - {{ptrW{1'b0}}, doPop};
    end
  end

endmodule
